/* common/nes_cfg.svh */
`ifndef NES_CFG_SVH
`define NES_CFG_SVH

// work ram, 2 KB mirrored up to $1FFF
`define RAM_ADDR_BITS   11
`define RAM_MIRROR_END  16'h2000

// ppu registers mirrored every 8 bytes up to $3FFF
`define PPU_END         16'h4000

// cartridge prg rom window
`define PRG_BASE        16'h8000

// joypad ports
`define JOY1_ADDR       16'h4016
`define JOY2_ADDR       16'h4017
`define JOY_OPEN_BUS    8'h40   // upper bits left on the bus by the address high byte

`endif

/* common/nes_bus_pkg.sv */
`include "nes_cfg.svh"

package nes_bus_pkg;

    typedef logic [15:0] cpu_addr_t;
    typedef logic [7:0]  cpu_data_t;
    typedef logic [`RAM_ADDR_BITS-1:0] ram_addr_t;  // index into the 2 KB work ram

    // read/write level as driven by the 6502
    localparam logic RW_READ  = 1'b1;
    localparam logic RW_WRITE = 1'b0;

    // which block a cpu cycle lands in
    typedef enum logic [2:0]
    {
        RANGE_NONE,
        RANGE_RAM,
        RANGE_PPU,
        RANGE_PRG,
        RANGE_JOY
    } address_range_e;

endpackage

/* common/nes_io_pkg.sv */
package nes_io_pkg;

    // selects one of the eight ppu registers $2000-$2007
    typedef logic [2:0] ppu_reg_sel_t;

    // active high, bit 0 is A
    // order A, B, Select, Start, Up, Down, Left, Right
    typedef logic [7:0] buttons_t;

endpackage

/* common/ram_bus_if.sv */
interface ram_bus_if;
    import nes_bus_pkg::*;

    logic      cs;
    ram_addr_t address;     // already masked to the mirror
    logic      rw;          // 1 read, 0 write
    cpu_data_t wdata;
    cpu_data_t rdata;       // follows address without a clock

    modport master
    (
        output cs, address, rw, wdata,
        input  rdata
    );

    modport target
    (
        input  cs, address, rw, wdata,
        output rdata
    );

endinterface

/* memory_map/cpu_memory_map.sv */
`include "nes_cfg.svh"

module cpu_memory_map
(
    input  logic                       i_clk,
    input  logic                       i_reset,

    // cpu side
    input  logic                       i_clk_en,
    input  nes_bus_pkg::cpu_addr_t     i_address,
    input  logic                       i_rw,
    input  nes_bus_pkg::cpu_data_t     i_data,       // written by the cpu
    output nes_bus_pkg::cpu_data_t     o_data,       // read by the cpu

    ram_bus_if.master                  ram,

    // prg rom
    output logic                       o_prg_cs,
    output nes_bus_pkg::cpu_addr_t     o_prg_address,
    input  nes_bus_pkg::cpu_data_t     i_prg_data,

    // ppu registers
    output logic                       o_ppu_cs,
    output nes_io_pkg::ppu_reg_sel_t   o_ppu_rs,
    output logic                       o_ppu_rw,
    output nes_bus_pkg::cpu_data_t     o_ppu_data,
    input  nes_bus_pkg::cpu_data_t     i_ppu_data,

    // controller port
    input  logic                       i_oe1_n,
    input  logic                       i_oe2_n,
    input  logic                       i_serial_n    // low while the current button is pressed
);
    import nes_bus_pkg::*;

    address_range_e range;
    logic           ram_cs;
    logic           ppu_write;
    cpu_data_t      ppu_data_hold;
    cpu_data_t      read_data;

    // decode only qualified cycles, anything else stays NONE
    always_comb
    begin
        range = RANGE_NONE;
        if (i_clk_en)
        begin
            if (i_address < `RAM_MIRROR_END)
                range = RANGE_RAM;
            else if (i_address < `PPU_END)
                range = RANGE_PPU;
            else if (i_address >= `PRG_BASE)
                range = RANGE_PRG;
            else if ((i_address == `JOY1_ADDR) || (i_address == `JOY2_ADDR))
                range = RANGE_JOY;
        end
    end

    assign ram_cs    = (range == RANGE_RAM);
    assign o_prg_cs  = (range == RANGE_PRG);
    assign o_ppu_cs  = (range == RANGE_PPU);
    assign ppu_write = o_ppu_cs && (i_rw == RW_WRITE);

    assign ram.cs      = ram_cs;
    assign ram.address = ram_cs ? i_address[`RAM_ADDR_BITS-1:0] : '0;  // 2 KB mirror
    assign ram.rw      = ram_cs ? i_rw : RW_READ;
    assign ram.wdata   = (ram_cs && (i_rw == RW_WRITE)) ? i_data : '0;

    assign o_prg_address = o_prg_cs ? i_address : '0;

    assign o_ppu_rs   = o_ppu_cs ? i_address[2:0] : '0;  // 8 byte mirror
    assign o_ppu_rw   = o_ppu_cs ? i_rw : RW_READ;       // idle as read when deselected
    assign o_ppu_data = ppu_write ? i_data : ppu_data_hold;

    // ppu data lines keep the last written byte between writes
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
            ppu_data_hold <= '0;
        else if (ppu_write)
            ppu_data_hold <= i_data;
    end

    // read data mux, zero on writes and idle cycles
    always_comb
    begin
        read_data = '0;
        if (i_rw == RW_READ)
        begin
            case (range)
                RANGE_RAM: read_data = ram.rdata;
                RANGE_PPU: read_data = i_ppu_data;
                RANGE_PRG: read_data = i_prg_data;
                RANGE_JOY:
                begin
                    if (!i_oe1_n)
                        read_data = `JOY_OPEN_BUS | {7'b0, ~i_serial_n};  // pressed reads 1
                    else if (!i_oe2_n)
                        read_data = `JOY_OPEN_BUS;  // port 2 has nothing pressed
                end
                default: read_data = '0;
            endcase
        end
    end

    assign o_data = read_data;

endmodule

/* verilog/work_ram.sv */
`include "nes_cfg.svh"

module work_ram
(
    input  logic       i_clk,
    ram_bus_if.target  bus
);
    import nes_bus_pkg::*;

    localparam int DEPTH = 2 ** `RAM_ADDR_BITS;

    cpu_data_t mem [DEPTH];  // contents undefined after power up

    // write lands on the rising edge of the cycle
    always_ff @(posedge i_clk)
    begin
        if (bus.cs && (bus.rw == RW_WRITE))
        begin
            mem[bus.address] <= bus.wdata;
        end
    end

    // asynchronous read, next cycle sees a fresh write
    assign bus.rdata = mem[bus.address];

endmodule

/* verilog/controller_port.sv */
`include "nes_cfg.svh"

module controller_port
(
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_clk_en,
    input  nes_bus_pkg::cpu_addr_t i_address,
    input  logic                   i_rw,
    input  nes_bus_pkg::cpu_data_t i_data,
    input  nes_io_pkg::buttons_t   i_buttons,
    output logic                   o_oe1_n,
    output logic                   o_oe2_n,
    output logic                   o_serial_n
);
    import nes_bus_pkg::*;
    import nes_io_pkg::*;

    logic     joy1_read;
    logic     joy2_read;
    logic     strobe_write;
    logic     strobe;
    buttons_t shift_n;  // active low, A sits in bit 0

    assign joy1_read    = i_clk_en && (i_rw == RW_READ) && (i_address == `JOY1_ADDR);
    assign joy2_read    = i_clk_en && (i_rw == RW_READ) && (i_address == `JOY2_ADDR);
    assign strobe_write = i_clk_en && (i_rw == RW_WRITE) && (i_address == `JOY1_ADDR);

    assign o_oe1_n    = ~joy1_read;
    assign o_oe2_n    = ~joy2_read;
    assign o_serial_n = shift_n[0];

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
            strobe <= 1'b0;
        else if (strobe_write)
            strobe <= i_data[0];  // $4016 bit 0 latches the pad
    end

    // parallel load while strobe is high, one bit per read otherwise
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
            shift_n <= '1;  // all released
        else if (strobe)
            shift_n <= ~i_buttons;
        else if (joy1_read)
            shift_n <= {1'b0, shift_n[7:1]};  // serial in tied low, reads 1 after bit 8
    end

endmodule

/* verilog/nes_cpu_bus.sv */
module nes_cpu_bus
(
    input  logic                     i_clk,
    input  logic                     i_reset,

    // cpu cycle
    input  logic                     i_clk_en,
    input  nes_bus_pkg::cpu_addr_t   i_address,
    input  logic                     i_rw,
    input  nes_bus_pkg::cpu_data_t   i_data,
    output nes_bus_pkg::cpu_data_t   o_data,

    // cartridge prg rom
    output logic                     o_prg_cs,
    output nes_bus_pkg::cpu_addr_t   o_prg_address,
    input  nes_bus_pkg::cpu_data_t   i_prg_data,

    // ppu
    output logic                     o_ppu_cs,
    output nes_io_pkg::ppu_reg_sel_t o_ppu_rs,
    output logic                     o_ppu_rw,
    output nes_bus_pkg::cpu_data_t   o_ppu_data,
    input  nes_bus_pkg::cpu_data_t   i_ppu_data,

    // joypad 1
    input  nes_io_pkg::buttons_t     i_buttons
);
    logic oe1_n;
    logic oe2_n;
    logic serial_n;

    ram_bus_if ram_bus ();

    cpu_memory_map u_cpu_memory_map
    (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_clk_en      (i_clk_en),
        .i_address     (i_address),
        .i_rw          (i_rw),
        .i_data        (i_data),
        .o_data        (o_data),
        .ram           (ram_bus.master),
        .o_prg_cs      (o_prg_cs),
        .o_prg_address (o_prg_address),
        .i_prg_data    (i_prg_data),
        .o_ppu_cs      (o_ppu_cs),
        .o_ppu_rs      (o_ppu_rs),
        .o_ppu_rw      (o_ppu_rw),
        .o_ppu_data    (o_ppu_data),
        .i_ppu_data    (i_ppu_data),
        .i_oe1_n       (oe1_n),
        .i_oe2_n       (oe2_n),
        .i_serial_n    (serial_n)
    );

    work_ram u_work_ram
    (
        .i_clk (i_clk),
        .bus   (ram_bus.target)
    );

    // watches the cpu bus directly for the $4016 strobe write
    controller_port u_controller_port
    (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_clk_en   (i_clk_en),
        .i_address  (i_address),
        .i_rw       (i_rw),
        .i_data     (i_data),
        .i_buttons  (i_buttons),
        .o_oe1_n    (oe1_n),
        .o_oe2_n    (oe2_n),
        .o_serial_n (serial_n)
    );

endmodule

/* tests/nes_bus_monitor.sv */
module nes_bus_monitor
(
    input  logic                     i_clk,
    input  logic                     i_reset,
    input  logic                     i_clk_en,
    input  nes_bus_pkg::cpu_addr_t   i_address,
    input  logic                     i_rw,
    input  nes_bus_pkg::cpu_data_t   i_data,
    input  nes_bus_pkg::cpu_data_t   i_rdata,
    input  logic                     i_prg_cs,
    input  nes_bus_pkg::cpu_addr_t   i_prg_address,
    input  logic                     i_ppu_cs,
    input  nes_io_pkg::ppu_reg_sel_t i_ppu_rs,
    input  logic                     i_ppu_rw,
    input  nes_bus_pkg::cpu_data_t   i_ppu_data,
    input  logic                     i_check,      // current cycle is a compared read
    input  nes_bus_pkg::cpu_data_t   i_expected,
    input  logic [127:0]             i_test_name,
    output int                       o_checks,
    output int                       o_errors
);
    timeunit 1ns;
    timeprecision 100ps;

    int   checks = 0;
    int   errors = 0;
    logic exp_prg_cs;
    logic exp_ppu_cs;

    // expected selects straight from the cpu memory map
    assign exp_prg_cs = i_clk_en && (i_address >= 16'h8000);
    assign exp_ppu_cs = i_clk_en && (i_address >= 16'h2000) && (i_address < 16'h4000);
    assign o_checks   = checks;
    assign o_errors   = errors;

    task automatic report_mismatch(input string what, input logic [15:0] expected,
                                   input logic [15:0] actual);
        $display("Fail %0s %0s expected %h actual %h", i_test_name, what, expected, actual);
        errors++;
    endtask

    always @(posedge i_clk)
    begin
        if (!i_reset)
        begin
            if (!i_clk_en && (i_prg_cs || i_ppu_cs || (i_rdata != 8'h00)))
            begin
                $display("chip select or read data active while clock enable low at %0t",
                         $time);
                errors++;
            end
            if ((i_prg_cs !== exp_prg_cs) || (i_ppu_cs !== exp_ppu_cs))
            begin
                $display("wrong chip select for address %h at %0t", i_address, $time);
                errors++;
            end
            if (i_prg_cs && (i_prg_address !== i_address))
                report_mismatch("prg_address", i_address, i_prg_address);
            if (i_ppu_cs)
            begin
                if (i_ppu_rs !== i_address[2:0])
                    report_mismatch("ppu_rs", {13'b0, i_address[2:0]}, {13'b0, i_ppu_rs});
                if (i_ppu_rw !== i_rw)
                    report_mismatch("ppu_rw", {15'b0, i_rw}, {15'b0, i_ppu_rw});
                if (!i_rw && (i_ppu_data !== i_data))
                    report_mismatch("ppu_data", {8'b0, i_data}, {8'b0, i_ppu_data});
            end
            if (i_clk_en && !i_rw && (i_rdata !== 8'h00))
                report_mismatch("write_data_out", 16'h0000, {8'b0, i_rdata});
            if (i_clk_en && i_rw && i_check)
            begin
                checks++;
                if (i_rdata !== i_expected)
                    report_mismatch("data", {8'b0, i_expected}, {8'b0, i_rdata});
            end
        end
    end

endmodule

/* tests/nes_bus_checker.sv */
module nes_bus_checker
(
    input logic                   i_clk,
    input logic                   i_reset,
    input logic                   i_clk_en,
    input logic                   i_rw,
    input logic                   i_prg_cs,
    input logic                   i_ppu_cs,
    input logic                   i_ram_cs,
    input nes_bus_pkg::cpu_data_t i_rdata
);
    timeunit 1ns;
    timeprecision 100ps;

    int failures = 0;  // failed assertions so far

    a_one_select: assert property (@(posedge i_clk) disable iff (i_reset)
        $onehot0({i_prg_cs, i_ppu_cs, i_ram_cs}))
        else
        begin
            failures++;
            $error("more than one chip select active");
        end

    // selects are pure decodes of a qualified cycle
    a_idle_no_select: assert property (@(posedge i_clk) disable iff (i_reset)
        !i_clk_en |-> !(i_prg_cs || i_ppu_cs || i_ram_cs))
        else
        begin
            failures++;
            $error("chip select active with clock enable low");
        end

    a_write_zero: assert property (@(posedge i_clk) disable iff (i_reset)
        !i_rw |-> (i_rdata == 8'h00))
        else
        begin
            failures++;
            $error("read data not zero during a write");
        end

endmodule

bind nes_cpu_bus nes_bus_checker u_nes_bus_checker
(
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_clk_en (i_clk_en),
    .i_rw     (i_rw),
    .i_prg_cs (o_prg_cs),
    .i_ppu_cs (o_ppu_cs),
    .i_ram_cs (ram_bus.cs),
    .i_rdata  (o_data)
);

/* tests/tb_nes_cpu_bus.sv */
module tb_nes_cpu_bus;
    timeunit 1ns;
    timeprecision 100ps;

    parameter int SEED = 36;
    localparam int MAX_OPS = 64;

    logic         clk;
    logic         reset;
    logic         clk_en;
    logic [15:0]  address;
    logic         rw;
    logic [7:0]   wdata;
    logic [7:0]   rdata;
    logic         prg_cs;
    logic [15:0]  prg_address;
    logic [7:0]   prg_data;
    logic         ppu_cs;
    logic [2:0]   ppu_rs;
    logic         ppu_rw;
    logic [7:0]   ppu_wdata;
    logic [7:0]   ppu_rdata;
    logic [7:0]   buttons;
    logic         check;
    logic [7:0]   expected;
    logic [127:0] test_name;
    int           checks;
    int           errors;
    int           local_errors = 0;
    int           assert_errors = 0;
    int           seed = SEED;
    int           cycles = 0;
    int           cycle_limit = 50;
    int           num_ops = 0;
    logic [7:0]   op_kind [MAX_OPS];
    logic [15:0]  op_addr [MAX_OPS];
    logic [7:0]   op_data [MAX_OPS];
    logic [127:0] op_name [MAX_OPS];

    // prg rom and ppu register models
    assign prg_data  = prg_address[7:0] ^ prg_address[15:8];
    assign ppu_rdata = 8'hA0 | {5'b0, ppu_rs};

    nes_cpu_bus u_nes_cpu_bus
    (
        .i_clk (clk), .i_reset (reset), .i_clk_en (clk_en), .i_address (address),
        .i_rw (rw), .i_data (wdata), .o_data (rdata),
        .o_prg_cs (prg_cs), .o_prg_address (prg_address), .i_prg_data (prg_data),
        .o_ppu_cs (ppu_cs), .o_ppu_rs (ppu_rs), .o_ppu_rw (ppu_rw),
        .o_ppu_data (ppu_wdata), .i_ppu_data (ppu_rdata), .i_buttons (buttons)
    );

    nes_bus_monitor u_nes_bus_monitor
    (
        .i_clk (clk), .i_reset (reset), .i_clk_en (clk_en), .i_address (address),
        .i_rw (rw), .i_data (wdata), .i_rdata (rdata),
        .i_prg_cs (prg_cs), .i_prg_address (prg_address),
        .i_ppu_cs (ppu_cs), .i_ppu_rs (ppu_rs), .i_ppu_rw (ppu_rw), .i_ppu_data (ppu_wdata),
        .i_check (check), .i_expected (expected), .i_test_name (test_name),
        .o_checks (checks), .o_errors (errors)
    );

    always #5 clk = ~clk;

    task automatic load_stimulus();
        int           fd;
        string        line;
        logic [7:0]   kind;
        logic [15:0]  addr;
        logic [7:0]   data;
        logic [127:0] name;
        fd = $fopen("tests/nes_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the stimulus file tests/nes_stimulus.txt");
            local_errors++;
            return;
        end
        while (!$feof(fd) && (num_ops < MAX_OPS))
        begin
            line = "";
            void'($fgets(line, fd));
            if ((line.len() > 1) && (line.getc(0) != "#"))
            begin
                if ($sscanf(line, "%c %h %h %s", kind, addr, data, name) == 4)
                begin
                    op_kind[num_ops] = kind;
                    op_addr[num_ops] = addr;
                    op_data[num_ops] = data;
                    op_name[num_ops] = name;
                    num_ops++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_op(input int idx);
        int idle;
        idle = {$random(seed)} % 3;  // 0 to 2 idle cycles before the op
        repeat (idle)
        begin
            @(negedge clk);
            clk_en = 1'b0;
            check  = 1'b0;
        end
        @(negedge clk);
        test_name = op_name[idx];
        check     = 1'b0;
        clk_en    = 1'b0;
        if ((op_kind[idx] == "W") && (op_addr[idx] == 16'hFFFF))
            buttons = op_data[idx];  // joypad model, not a bus cycle
        else if ((op_kind[idx] == "W") || (op_kind[idx] == "R"))
        begin
            clk_en   = 1'b1;
            address  = op_addr[idx];
            rw       = (op_kind[idx] == "R");
            wdata    = (op_kind[idx] == "W") ? op_data[idx] : 8'h00;
            expected = op_data[idx];
            check    = (op_kind[idx] == "R");
        end
        else
        begin
            $display("unknown operation in stimulus line %0d", idx);
            local_errors++;
        end
    endtask

    // run limit from the stimulus length, at most 3 cycles per op
    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= cycle_limit)
        begin
            $display("timeout after %0d cycles, the stimulus did not finish", cycles);
            $display("Errors found");
            $finish;
        end
    end

    initial
    begin
        clk       = 1'b0;
        reset     = 1'b1;
        clk_en    = 1'b0;
        address   = 16'h0000;
        rw        = 1'b1;
        wdata     = 8'h00;
        buttons   = 8'h00;
        check     = 1'b0;
        expected  = 8'h00;
        test_name = '0;
        load_stimulus();
        cycle_limit = 4 * num_ops + 50;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < num_ops; i++)
            drive_op(i);
        @(negedge clk);
        clk_en = 1'b0;
        check  = 1'b0;
        @(negedge clk);
        assert_errors = u_nes_cpu_bus.u_nes_bus_checker.failures;
        $display("ops %0d, checks %0d, errors %0d, assertion failures %0d",
                 num_ops, checks, errors + local_errors, assert_errors);
        if ((errors + local_errors + assert_errors == 0) && (num_ops > 0))
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

/* nes_cpu_bus.f */
+incdir+common
common/nes_bus_pkg.sv
common/nes_io_pkg.sv
common/ram_bus_if.sv
memory_map/cpu_memory_map.sv
verilog/work_ram.sv
verilog/controller_port.sv
verilog/nes_cpu_bus.sv
tests/nes_bus_monitor.sv
tests/nes_bus_checker.sv
tests/tb_nes_cpu_bus.sv

/* Makefile */
# Verilator build and run for the NES CPU bus testbench

TOP       ?= tb_nes_cpu_bus
SEED      ?= 36
LOG       ?= sim.log
FILELIST  ?= nes_cpu_bus.f
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
RUN_FLAGS ?= +verilator+error+limit+100

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -GSEED=$(SEED) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "No errors" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/nes_stimulus.txt */
# columns: op (R read and compare, W write) address data test_name, all hex
# a W to address ffff sets the joypad buttons and puts no cycle on the bus
W 0123 5A ram_mirror
R 0123 5A ram_mirror
R 0923 5A ram_mirror
R 1923 5A ram_mirror
R 8000 80 prg_read
R C3A5 66 prg_read
R FFFF 00 prg_read
W 2006 3C ppu_write
R 3FF9 A1 ppu_read
W FFFF A5 joy_buttons
W 4016 01 joy_strobe
W 4016 00 joy_strobe
R 4016 41 joy_a
R 4016 40 joy_b
R 4016 41 joy_select
R 4016 40 joy_start
R 4016 40 joy_up
R 4016 41 joy_down
R 4016 40 joy_left
R 4016 41 joy_right
R 4016 41 joy_after
R 4016 41 joy_after
R 4017 40 joy2_read
R 4000 00 unmapped
R 5555 00 unmapped
R 7FFF 00 unmapped
